/* design/rom_check_counter.sv */
/*
 * Redundant digest word counter
 * Up count plus complement copy, flags any disagreement
 */
`default_nettype none

module rom_check_counter (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       incr_i,
  output rom_check_pkg::digest_idx_t cnt_o,
  output logic                       err_o
);
  import rom_check_pkg::*;

  // Primary count
  digest_idx_t cnt_q;
  // Complement copy, counts down in step
  digest_idx_t cnt_n_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      cnt_n_q <= '1;
    end else if (incr_i) begin
      cnt_q   <= cnt_q + digest_idx_t'(1);
      cnt_n_q <= cnt_n_q - digest_idx_t'(1);
    end
  end

  assign cnt_o = cnt_q;

  // Copies must stay bitwise complementary
  assign err_o = (cnt_q != ~cnt_n_q);

  // Caller stops incrementing at the last digest word, no wrap allowed
  incr_at_top_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    incr_i |-> (cnt_q != DigestLastIdx)
  ) else $error("counter incremented at top count");

endmodule

`default_nettype wire

/* design/rom_check_pkg.sv */
/*
 * ROM integrity checker package
 * Sizes, vector types, multi-bit booleans and the digest seed
 */
`default_nettype none

package rom_check_pkg;

  // Basic sizes
  localparam int unsigned WordW       = 32;
  localparam int unsigned RomWords    = 32;
  localparam int unsigned DigestWords = 2;

  // Derived widths
  localparam int unsigned RomAddrW   = $clog2(RomWords);
  localparam int unsigned DigestIdxW = $clog2(DigestWords);

  typedef logic [WordW-1:0]             rom_word_t;
  typedef logic [RomAddrW-1:0]          rom_addr_t;
  typedef logic [DigestIdxW-1:0]        digest_idx_t;
  // Word 0 sits in the low bits
  typedef logic [DigestWords*WordW-1:0] digest_t;

  // Multi-bit boolean, any other code counts as invalid
  typedef logic [3:0] mubi4_t;
  localparam mubi4_t MuBi4True  = 4'h6;
  localparam mubi4_t MuBi4False = 4'h9;

  // Address landmarks
  localparam rom_addr_t RomLastAddr = rom_addr_t'(RomWords - 1);
  // First of the expected digest words at the top of the ROM
  localparam rom_addr_t ExpBaseAddr = rom_addr_t'(RomWords - DigestWords);

  localparam digest_idx_t DigestLastIdx = digest_idx_t'(DigestWords - 1);

  // Start value of every digest lane
  localparam rom_word_t DigestSeed = 32'hA5C3_0F1E;

  // Plain boolean to mubi code
  function automatic mubi4_t mubi4_from_bool(logic val);
    return val ? MuBi4True : MuBi4False;
  endfunction

endpackage

`default_nettype wire

/* design/rom_check_top.sv */
/*
 * ROM integrity checker top
 * Scanner and comparator joined through the digest interface
 */
`default_nettype none

module rom_check_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  // ROM read port, one-cycle latency
  output logic                     rom_req_o,
  output rom_check_pkg::rom_addr_t rom_addr_o,
  input  rom_check_pkg::rom_word_t rom_rdata_i,
  // Computed digest for downstream consumers
  output rom_check_pkg::digest_t   digest_o,
  output logic                     done_o,
  output rom_check_pkg::mubi4_t    good_o,
  output logic                     alert_o
);

  rom_digest_if dig_if ();

  rom_digest_scan u_scan (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .rom_req_o   (rom_req_o),
    .rom_addr_o  (rom_addr_o),
    .rom_rdata_i (rom_rdata_i),
    .dig         (dig_if.producer)
  );

  // Start seen here too, for misuse alerts only
  rom_compare u_compare (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (start_i),
    .dig     (dig_if.consumer),
    .done_o  (done_o),
    .good_o  (good_o),
    .alert_o (alert_o)
  );

  assign digest_o = dig_if.digest;

endmodule

`default_nettype wire

/* design/rom_compare.sv */
/*
 * Digest comparator
 * Walks digest words one per cycle against expected words, reports done, good, alert
 */
`default_nettype none

module rom_compare (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  rom_digest_if.consumer        dig,
  output logic                  done_o,
  output rom_check_pkg::mubi4_t good_o,
  output logic                  alert_o
);
  import rom_check_pkg::*;

  // Sparse codes, pairwise distance of at least 3
  typedef enum logic [4:0] {
    CmpWaiting  = 5'b00100,
    CmpChecking = 5'b10010,
    CmpDone     = 5'b11001
  } cmp_state_e;

  cmp_state_e state_q, state_d;

  logic        matches_q, matches_d;
  mubi4_t      good_q, good_d;
  logic        fsm_alert;

  // Word counter
  digest_idx_t cnt;
  logic        cnt_incr;
  logic        cnt_err;

  rom_word_t   digest_word;
  rom_word_t   exp_word;

  always_comb begin
    state_d   = state_q;
    fsm_alert = 1'b0;
    case (state_q)
      CmpWaiting: begin
        if (dig.check_start && dig.digest_valid) begin
          state_d = CmpChecking;
        end
      end
      CmpChecking: begin
        if (cnt == DigestLastIdx) begin
          state_d = CmpDone;
        end
      end
      CmpDone: begin
        // Terminal until reset
        state_d = CmpDone;
      end
      default: begin
        fsm_alert = 1'b1;
      end
    endcase
  end

  // Step through words, stop at the last one
  assign cnt_incr = (state_q == CmpChecking) && (cnt != DigestLastIdx);

  rom_check_counter u_counter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .incr_i (cnt_incr),
    .cnt_o  (cnt),
    .err_o  (cnt_err)
  );

  // Current word pair
  assign digest_word = dig.digest[{cnt, 5'd0} +: WordW];
  assign exp_word    = dig.exp_digest[{cnt, 5'd0} +: WordW];

  // Sticky match, only updated while checking
  assign matches_d = (state_q == CmpChecking) ? (matches_q && (digest_word == exp_word))
                                              : matches_q;

  // Good follows done in the same cycle
  assign good_d = (state_d == CmpDone) ? mubi4_from_bool(matches_d) : MuBi4False;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= CmpWaiting;
      matches_q <= 1'b1;
      good_q    <= MuBi4False;
    end else begin
      state_q   <= state_d;
      matches_q <= matches_d;
      good_q    <= good_d;
    end
  end

  assign done_o = (state_q == CmpDone);
  assign good_o = good_q;

  // Consistency checks
  logic start_alert;
  logic wait_cnt_alert;
  logic done_cnt_alert;

  // Start only legal while waiting
  assign start_alert    = start_i && (state_q != CmpWaiting);
  // Count parked at zero before checking
  assign wait_cnt_alert = (state_q == CmpWaiting) && (cnt != '0);
  // Count at last word once done
  assign done_cnt_alert = (state_q == CmpDone) && (cnt != DigestLastIdx);

  assign alert_o = fsm_alert | start_alert | wait_cnt_alert | done_cnt_alert | cnt_err;

  // Only the three legal codes
  state_legal_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q inside {CmpWaiting, CmpChecking, CmpDone}
  ) else $error("comparator in illegal state");

  // No way back from done without reset
  done_final_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    done_o |=> (state_q != CmpWaiting)
  ) else $error("comparator left done state");

endmodule

`default_nettype wire

/* design/rom_digest_if.sv */
/*
 * Digest hand-over between ROM scanner and comparator
 */
`default_nettype none

interface rom_digest_if;
  import rom_check_pkg::*;

  // One-cycle pulse, first cycle of digest_valid
  logic    check_start;
  // Computed digest, stable once valid
  digest_t digest;
  // Digest read from the top ROM words
  digest_t exp_digest;
  // Level, held until reset
  logic    digest_valid;

  modport producer (
    output check_start,
    output digest,
    output exp_digest,
    output digest_valid
  );

  modport consumer (
    input check_start,
    input digest,
    input exp_digest,
    input digest_valid
  );

endinterface

`default_nettype wire

/* design/rom_digest_scan.sv */
/*
 * ROM scanner
 * Reads every ROM word, folds data into a two-lane digest, captures expected digest
 */
`default_nettype none

module rom_digest_scan (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  output logic                     rom_req_o,
  output rom_check_pkg::rom_addr_t rom_addr_o,
  input  rom_check_pkg::rom_word_t rom_rdata_i,
  rom_digest_if.producer           dig
);
  import rom_check_pkg::*;

  typedef enum logic [1:0] {
    ScanIdle     = 2'b00,
    ScanReading  = 2'b01,
    ScanDraining = 2'b11,
    ScanFinished = 2'b10
  } scan_state_e;

  scan_state_e state_q, state_d;

  // Next address to request
  rom_addr_t addr_q;
  // Read data return tracking, one cycle behind the request
  logic      rvalid_q;
  rom_addr_t ridx_q;

  // Digest lanes and expected words
  rom_word_t lane_q [DigestWords];
  rom_word_t exp_q  [DigestWords];

  logic check_start_q;
  logic start_accept;

  // Start only taken from idle, once per reset
  assign start_accept = start_i && (state_q == ScanIdle);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ScanIdle: begin
        if (start_i) begin
          state_d = ScanReading;
        end
      end
      ScanReading: begin
        // Last request goes out this cycle
        if (addr_q == RomLastAddr) begin
          state_d = ScanDraining;
        end
      end
      ScanDraining: begin
        // Last word returns here
        state_d = ScanFinished;
      end
      ScanFinished: begin
        state_d = ScanFinished;
      end
      default: begin
        state_d = ScanIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= ScanIdle;
      addr_q        <= '0;
      rvalid_q      <= 1'b0;
      check_start_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      rvalid_q <= rom_req_o;
      if (state_q == ScanReading) begin
        addr_q <= addr_q + rom_addr_t'(1);
      end
      // Pulse lines up with first cycle of Finished
      check_start_q <= (state_q == ScanDraining);
    end
  end

  // ROM request port
  assign rom_req_o  = (state_q == ScanReading);
  assign rom_addr_o = addr_q;

  // Data path, no reset needed
  always_ff @(posedge clk_i) begin
    ridx_q <= rom_addr_o;
    if (start_accept) begin
      for (int i = 0; i < DigestWords; i++) begin
        lane_q[i] <= DigestSeed;
      end
    end else if (rvalid_q) begin
      if (ridx_q < ExpBaseAddr) begin
        // Rotate left by one, then XOR in the word
        lane_q[digest_idx_t'(ridx_q)] <=
          {lane_q[digest_idx_t'(ridx_q)][WordW-2:0], lane_q[digest_idx_t'(ridx_q)][WordW-1]}
          ^ rom_rdata_i;
      end else begin
        exp_q[digest_idx_t'(ridx_q - ExpBaseAddr)] <= rom_rdata_i;
      end
    end
  end

  // Pack lanes, word 0 low
  always_comb begin
    for (int i = 0; i < DigestWords; i++) begin
      dig.digest[i*WordW +: WordW]     = lane_q[i];
      dig.exp_digest[i*WordW +: WordW] = exp_q[i];
    end
  end

  assign dig.digest_valid = (state_q == ScanFinished);
  assign dig.check_start  = check_start_q;

  // Address range while requesting
  addr_in_range_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rom_req_o |-> (int'(rom_addr_o) < RomWords)
  ) else $error("ROM address out of range");

  // Digest stays valid until reset
  valid_sticky_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dig.digest_valid |=> dig.digest_valid
  ) else $error("digest_valid fell before reset");

endmodule

`default_nettype wire

/* project.f */
design/rom_check_pkg.sv
design/rom_digest_if.sv
design/rom_check_counter.sv
design/rom_digest_scan.sv
design/rom_compare.sv
design/rom_check_top.sv
sim/rom_check_monitor.sv
sim/tb_rom_check.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ROM checker testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_rom_check -Mdir obj_dir -o tb_rom_check \
  && ./obj_dir/tb_rom_check | tee sim.log \
  || { echo "Build or simulation failed"; exit 1; }

grep -q "^Result: PASSED$" sim.log && exit 0 || exit 1

/* sim/rom_check_monitor.sv */
/*
 * ROM checker monitor
 * Folds the returned ROM words into a model digest and compares the DUT outputs
 */
`default_nettype none

module rom_check_monitor (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  input  logic                     rom_req_i,
  input  rom_check_pkg::rom_addr_t rom_addr_i,
  input  rom_check_pkg::rom_word_t rom_rdata_i,
  input  rom_check_pkg::digest_t   digest_i,
  input  logic                     done_i,
  input  rom_check_pkg::mubi4_t    good_i,
  input  logic                     alert_i,
  input  int                       test_id_i,
  input  logic                     test_end_i,
  input  logic                     want_done_i,
  output int                       tests_o,
  output int                       failed_o,
  output int                       errors_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import rom_check_pkg::*;

  // Model lanes and expected words
  rom_word_t lane [DigestWords];
  rom_word_t exp_word [DigestWords];
  rom_word_t old;
  // Requests still due from the scanner
  int        req_left;
  logic      started;
  // Data return one cycle behind the request
  logic      ret_pend;
  rom_addr_t ret_addr;
  logic      last_ret;
  // Comparator leaves waiting two cycles after the last return
  logic      valid_next;
  logic      cmp_busy;
  logic      done_seen;
  mubi4_t    good_exp;
  int        test_errs = 0;
  int        tests = 0;
  int        failed = 0;
  int        errors = 0;

  function automatic string test_name(int id);
    case (id)
      1: return "idle_after_reset";
      2: return "matching_digest";
      3: return "mismatch_word0";
      4: return "mismatch_word1";
      5: return "start_while_busy";
      default: return $sformatf("random_run_%0d", id - 5);
    endcase
  endfunction

  task automatic report_value(string what, logic [63:0] exp_val, logic [63:0] act_val);
    $display("Error: %s: %s expected %h actual %h", test_name(test_id_i), what, exp_val,
             act_val);
    test_errs++;
  endtask

  task automatic report_fault(string what);
    $display("%s: %s", test_name(test_id_i), what);
    test_errs++;
  endtask

  // Sampled mid-cycle between the drive points
  always @(negedge clk_i) begin
    if (rst_ni !== 1'b1) begin
      for (int i = 0; i < DigestWords; i++) begin
        lane[i]     = DigestSeed;
        exp_word[i] = '0;
      end
      req_left   = 0;
      started    = 1'b0;
      ret_pend   = 1'b0;
      ret_addr   = '0;
      last_ret   = 1'b0;
      valid_next = 1'b0;
      cmp_busy   = 1'b0;
      done_seen  = 1'b0;
    end else begin
      // Absorb the word returned this cycle
      last_ret = 1'b0;
      if (ret_pend) begin
        if (int'(ret_addr) < RomWords - DigestWords) begin
          old = lane[int'(ret_addr) % DigestWords];
          lane[int'(ret_addr) % DigestWords] = {old[WordW-2:0], old[WordW-1]} ^ rom_rdata_i;
        end else begin
          exp_word[int'(ret_addr) - (RomWords - DigestWords)] = rom_rdata_i;
        end
        last_ret = (int'(ret_addr) == RomWords - 1);
      end
      good_exp = (lane[0] == exp_word[0] && lane[1] == exp_word[1]) ? MuBi4True : MuBi4False;

      if (rom_req_i !== (req_left > 0)) report_value("rom_req_o", req_left > 0, rom_req_i);
      if (rom_req_i === 1'b1 && int'(rom_addr_i) != RomWords - req_left) begin
        report_value("rom_addr_o", RomWords - req_left, rom_addr_i);
      end
      if (alert_i !== (start_i && cmp_busy)) begin
        report_value("alert_o", start_i && cmp_busy, alert_i);
      end

      if (done_i === 1'b1) begin
        if (!done_seen) begin
          if (!cmp_busy) report_fault("done_o rose before the digest words were compared");
          if (digest_i !== {lane[1], lane[0]}) begin
            report_value("digest_o", {lane[1], lane[0]}, digest_i);
          end
          done_seen = 1'b1;
        end
        // Result must hold for as long as done_o is high
        if (good_i !== good_exp) report_value("good_o", good_exp, good_i);
      end else begin
        if (done_seen) report_fault("done_o fell before reset");
        if (good_i !== MuBi4False) report_value("good_o", MuBi4False, good_i);
      end

      // Advance the model to the next cycle
      if (req_left > 0) req_left--;
      if (start_i && !started) begin
        started  = 1'b1;
        req_left = RomWords;
      end
      ret_pend   = rom_req_i;
      ret_addr   = rom_addr_i;
      cmp_busy   = cmp_busy || valid_next;
      valid_next = last_ret;
    end

    if (test_end_i) begin
      if (want_done_i && !done_seen) report_fault("done_o never rose");
      tests++;
      if (test_errs == 0) begin
        $display("Test %s: ok", test_name(test_id_i));
      end else begin
        $display("Test %s: failed with %0d errors", test_name(test_id_i), test_errs);
        failed++;
      end
      errors += test_errs;
      test_errs = 0;
    end
  end

  assign tests_o  = tests;
  assign failed_o = failed;
  assign errors_o = errors;

endmodule

`default_nettype wire

/* sim/tb_rom_check.sv */
/*
 * ROM integrity checker testbench
 * Clock, reset, ROM model, random contents, watchdog and test sequence
 */
`default_nettype none

module tb_rom_check;
  timeunit 1ns;
  timeprecision 100ps;
  import rom_check_pkg::*;

  localparam int ClkPeriod = 4;
  localparam int NumTests  = 13;
  localparam int DoneLimit = RomWords + DigestWords + 20;

  logic      clk_i;
  logic      rst_ni;
  logic      start_i;
  logic      rom_req_o;
  rom_addr_t rom_addr_o;
  rom_word_t rom_rdata_i;
  digest_t   digest_o;
  logic      done_o;
  mubi4_t    good_o;
  logic      alert_o;

  int        test_id;
  logic      test_end;
  logic      want_done;
  int        tests;
  int        failed;
  int        errors;
  int        seed = 82;

  // ROM contents and read pipeline
  rom_word_t rom_mem [RomWords];
  logic      rd_req;
  rom_addr_t rd_addr;

  rom_check_top dut_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .rom_req_o   (rom_req_o),
    .rom_addr_o  (rom_addr_o),
    .rom_rdata_i (rom_rdata_i),
    .digest_o    (digest_o),
    .done_o      (done_o),
    .good_o      (good_o),
    .alert_o     (alert_o)
  );

  rom_check_monitor u_monitor (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .rom_req_i   (rom_req_o),
    .rom_addr_i  (rom_addr_o),
    .rom_rdata_i (rom_rdata_i),
    .digest_i    (digest_o),
    .done_i      (done_o),
    .good_i      (good_o),
    .alert_i     (alert_o),
    .test_id_i   (test_id),
    .test_end_i  (test_end),
    .want_done_i (want_done),
    .tests_o     (tests),
    .failed_o    (failed),
    .errors_o    (errors)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Request seen mid-cycle, data answered just after the next edge
  always @(negedge clk_i) begin
    rd_req  <= rom_req_o;
    rd_addr <= rom_addr_o;
  end

  always @(posedge clk_i) begin
    #1;
    rom_rdata_i = rd_req ? rom_mem[rd_addr] : '0;
  end

  // Digest of the current ROM data words
  function automatic digest_t model_digest();
    rom_word_t lane [DigestWords];
    rom_word_t old;
    lane[0] = DigestSeed;
    lane[1] = DigestSeed;
    for (int k = 0; k < RomWords - DigestWords; k++) begin
      old = lane[k % DigestWords];
      lane[k % DigestWords] = {old[WordW-2:0], old[WordW-1]} ^ rom_mem[k];
    end
    return {lane[1], lane[0]};
  endfunction

  // Random data, matching expected words, then an optional flip
  task automatic load_rom(input int word_sel, input rom_word_t flip);
    digest_t dgst;
    for (int i = 0; i < RomWords; i++) begin
      rom_mem[i] = $random(seed);
    end
    dgst = model_digest();
    rom_mem[RomWords - 2] = dgst[WordW-1:0];
    rom_mem[RomWords - 1] = dgst[2*WordW-1:WordW];
    rom_mem[RomWords - 2 + word_sel] = rom_mem[RomWords - 2 + word_sel] ^ flip;
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    #1 rst_ni = 1'b0;
    start_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #1 rst_ni = 1'b1;
  endtask

  task automatic pulse_start();
    @(posedge clk_i);
    #1 start_i = 1'b1;
    @(posedge clk_i);
    #1 start_i = 1'b0;
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (cycles < DoneLimit) begin
      @(negedge clk_i);
      if (done_o === 1'b1) break;
      cycles++;
    end
  endtask

  task automatic end_test();
    @(posedge clk_i);
    #1 test_end = 1'b1;
    @(posedge clk_i);
    #1 test_end = 1'b0;
  endtask

  task automatic run_check(input int id, input int word_sel, input rom_word_t flip,
                           input bit extra_starts);
    test_id   = id;
    want_done = 1'b1;
    load_rom(word_sel, flip);
    apply_reset();
    pulse_start();
    if (extra_starts) begin
      // Second start lands in the middle of the scan
      repeat (8) @(posedge clk_i);
      pulse_start();
    end
    wait_done();
    if (extra_starts) begin
      pulse_start();
      repeat (2) @(posedge clk_i);
    end
    end_test();
  endtask

  initial begin
    int        mismatch;
    int        word_sel;
    rom_word_t flip;
    rst_ni      = 1'b0;
    start_i     = 1'b0;
    rom_rdata_i = '0;
    test_id     = 1;
    test_end    = 1'b0;
    want_done   = 1'b0;

    // Idle with start held low
    want_done = 1'b0;
    apply_reset();
    repeat (10) @(posedge clk_i);
    end_test();

    run_check(2, 0, '0, 1'b0);
    run_check(3, 0, rom_word_t'(1) << ($unsigned($random(seed)) % WordW), 1'b0);
    run_check(4, 1, rom_word_t'($random(seed)) | rom_word_t'(1), 1'b0);
    run_check(5, 0, '0, 1'b1);

    for (int r = 0; r < 8; r++) begin
      mismatch = $random(seed) & 1;
      word_sel = $random(seed) & 1;
      flip     = '0;
      if (mismatch != 0) begin
        flip = rom_word_t'(1) << ($unsigned($random(seed)) % WordW);
      end
      run_check(6 + r, word_sel, flip, 1'b0);
    end

    @(posedge clk_i);
    $display("Tests run: %0d, failed: %0d, errors: %0d", tests, failed, errors);
    if (errors == 0 && failed == 0 && tests == NumTests) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Bound on the whole run
  initial begin
    repeat (NumTests * (RomWords + DigestWords + 20)) @(posedge clk_i);
    $display("Timeout: the tests did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire
